// ==== qla_defines.svh ====
/*
 * Board constants for the QLA register bus. Address layout is space in 15:12,
 * channel in 7:4 and offset in 3:0. Axis i lives on channel i+1.
 */

`ifndef QLA_DEFINES_SVH
`define QLA_DEFINES_SVH

// board size
`define QLA_NUM_AXES        4

// ---------------------------------------------------
// address fields
// ---------------------------------------------------
`define QLA_ADDR_MAIN       4'h0        // main register space, addr[15:12]
`define QLA_OFF_STATUS      4'h0        // channel 0 status word
`define QLA_OFF_ADC_DATA    4'h0        // per-axis feedback read
`define QLA_OFF_DAC_CTRL    4'h1        // per-axis command read/write

// ---------------------------------------------------
// current values and safety
// ---------------------------------------------------
`define QLA_DAC_MID         16'h8000    // offset-binary zero
`define QLA_SAFETY_MARGIN   16'h0100    // slack over 2x command
`define QLA_SAFETY_COUNT    4           // consecutive bad samples to trip

// real-time block size in quadlets
`define QLA_RT_WORDS        5

`endif

// ==== qla_pkg.sv ====
/*
 * Shared types for the QLA register bus. Widths follow qla_defines.svh.
 */

`include "qla_defines.svh"

package qla_pkg;

    typedef logic [15:0] reg_addr_t;                    // board register address
    typedef logic [31:0] reg_data_t;                    // quadlet
    typedef logic [15:0] dac_word_t;                    // offset-binary current
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;      // one bit per axis
    typedef logic [2:0] rt_addr_t;                      // word index in rt block

    // internal write bus, one write per cycle
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        reg_data_t wdata;
    } wr_bus_t;

    // real-time block input
    typedef struct packed {
        logic      wen;
        rt_addr_t  waddr;
        reg_data_t wdata;
    } rt_wr_t;

    // host side of the four-phase port
    typedef struct packed {
        logic      req;
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } host_req_t;

    typedef enum logic {rt_idle, rt_replay} rt_state_t;

endpackage

// ==== host_port.sv ====
/*
 * Four-phase req/ack host port. Host must hold addr/data stable while req is
 * high and keep req low until ack drops. Reads take 2 cycles to ack.
 */

module host_port import qla_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  host_req_t host,
    output logic      ack,
    output reg_data_t rdata,
    output wr_bus_t   host_wr,
    output logic      host_wr_pending,
    input  logic      host_wr_done,
    output reg_addr_t raddr,
    input  reg_data_t reg_rdata
);

    typedef enum logic [2:0] {
        hp_idle,        // waiting for req
        hp_rd_addr,     // raddr out, regs sampling
        hp_rd_data,     // reg_rdata valid
        hp_wr_wait,     // write pending on bus mux
        hp_ack          // ack high until req drops
    } hp_state_t;

    hp_state_t state;
    reg_addr_t addr_q;      // latched host address
    reg_data_t wdata_q;     // latched write data

    assign raddr           = addr_q;
    assign host_wr_pending = (state == hp_wr_wait);
    assign host_wr         = '{wen: host_wr_pending, waddr: addr_q, wdata: wdata_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= hp_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                hp_idle:    if (host.req) state <= host.write ? hp_wr_wait : hp_rd_addr;
                hp_rd_addr: state <= hp_rd_data;
                hp_rd_data: begin
                    ack   <= 1'b1;              // rdata captured on same edge
                    state <= hp_ack;
                end
                hp_wr_wait: if (host_wr_done) begin
                    ack   <= 1'b1;              // write went out last cycle
                    state <= hp_ack;
                end
                hp_ack:     if (!host.req) begin
                    ack   <= 1'b0;
                    state <= hp_idle;
                end
                default:    state <= hp_idle;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (state == hp_idle && host.req) begin
            addr_q  <= host.addr;
            wdata_q <= host.wdata;
        end
        if (state == hp_rd_data) rdata <= reg_rdata;   // held while ack high
    end

endmodule

// ==== rt_block_writer.sv ====
/*
 * Real-time block capture and replay. Replay owns the write bus and host writes
 * stall until it ends. Only one extra replay is queued; later blocks merge into it.
 */

`include "qla_defines.svh"

module rt_block_writer import qla_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  rt_wr_t  rt,
    input  wr_bus_t host_wr,
    input  logic    host_wr_pending,
    output logic    host_wr_done,
    output wr_bus_t bus
);

    localparam rt_addr_t LAST = rt_addr_t'(`QLA_RT_WORDS - 1);

    reg_data_t cap_buf  [`QLA_RT_WORDS];   // capture buffer
    reg_data_t cap_next [`QLA_RT_WORDS];   // buffer incl. this cycle's word
    reg_data_t snap     [`QLA_RT_WORDS];   // replay snapshot
    rt_state_t state;
    rt_addr_t  idx;         // replay beat
    logic      queued;      // one replay waiting
    logic      rt_last;     // word 4 arriving
    logic      last_beat;
    logic      start;
    rt_addr_t  word_sel;
    logic [3:0] chan;

    assign rt_last   = rt.wen && (rt.waddr == LAST);
    assign last_beat = (state == rt_replay) && (idx == LAST);
    // new block from idle, or back-to-back after current replay
    assign start     = (rt_last && state == rt_idle) || (last_beat && (queued || rt_last));

    always_comb begin
        for (int i = 0; i < `QLA_RT_WORDS; i++) cap_next[i] = cap_buf[i];
        if (rt.wen && rt.waddr <= LAST) cap_next[rt.waddr] = rt.wdata;
    end

    // ---------------------------------------------------
    // replay control
    // ---------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= rt_idle;
            idx    <= '0;
            queued <= 1'b0;
        end else begin
            if (start) begin
                state  <= rt_replay;
                idx    <= '0;
                queued <= 1'b0;
            end else if (last_beat) begin
                state  <= rt_idle;
            end else if (state == rt_replay) begin
                idx    <= idx + rt_addr_t'(1);
            end
            if (rt_last && state == rt_replay && !last_beat) queued <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        cap_buf <= cap_next;
        if (start) snap <= cap_next;       // freeze block for replay
    end

    // beats 0..3 -> axis 1..4 commands, beat 4 -> control word to status
    assign word_sel = (idx == LAST) ? '0 : idx + rt_addr_t'(1);
    assign chan     = (idx == LAST) ? 4'h0 : {1'b0, idx} + 4'h1;

    // ---------------------------------------------------
    // write bus mux, replay wins
    // ---------------------------------------------------
    always_comb begin
        if (state == rt_replay) begin
            bus.wen      = 1'b1;
            bus.waddr    = {`QLA_ADDR_MAIN, 4'h0, chan,
                            (idx == LAST) ? `QLA_OFF_STATUS : `QLA_OFF_DAC_CTRL};
            bus.wdata    = snap[word_sel];
            host_wr_done = 1'b0;            // host stalls
        end else begin
            bus          = host_wr;
            host_wr_done = host_wr_pending; // granted this cycle
        end
    end

endmodule

// ==== axis_regs.sv ====
/*
 * Board registers in the main space. Reads return one cycle after raddr.
 * Address bits 11:8 must be zero. A safety disable masks amp_enable at once
 * and drops the stored enable, so the host must re-enable the axis.
 */

`include "qla_defines.svh"

module axis_regs import qla_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] board_id,
    input  wr_bus_t    bus,
    input  reg_addr_t  raddr,
    output reg_data_t  rdata,
    input  dac_word_t  fb [`QLA_NUM_AXES],
    input  axis_mask_t amp_disable,
    output axis_mask_t clear_disable,
    output dac_word_t  dac_cmd [`QLA_NUM_AXES],
    output axis_mask_t amp_enable
);

    axis_mask_t enable_q;       // stored enables
    logic       wr_main;
    logic       wr_status;
    logic       rd_main;
    logic [3:0] wr_chan;
    logic [3:0] wr_off;
    logic [3:0] rd_chan;
    logic [3:0] rd_off;
    reg_data_t  rd_next;

    assign wr_chan   = bus.waddr[7:4];
    assign wr_off    = bus.waddr[3:0];
    assign wr_main   = bus.wen && bus.waddr[15:12] == `QLA_ADDR_MAIN && bus.waddr[11:8] == 4'h0;
    assign wr_status = wr_main && wr_chan == 4'h0 && wr_off == `QLA_OFF_STATUS;

    assign rd_chan   = raddr[7:4];
    assign rd_off    = raddr[3:0];
    assign rd_main   = raddr[15:12] == `QLA_ADDR_MAIN && raddr[11:8] == 4'h0;

    assign amp_enable = enable_q & ~amp_disable;   // disable wins immediately

    // enabling an axis clears its safety latch on the same edge
    always_comb begin
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            clear_disable[i] = wr_status && bus.wdata[8 + i] && bus.wdata[i];
        end
    end

    // ---------------------------------------------------
    // write decode
    // ---------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= '0;
            for (int i = 0; i < `QLA_NUM_AXES; i++) dac_cmd[i] <= `QLA_DAC_MID;
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (amp_disable[i]) enable_q[i] <= 1'b0;
                if (wr_main && wr_chan == 4'(i + 1) && wr_off == `QLA_OFF_DAC_CTRL)
                    dac_cmd[i] <= bus.wdata[15:0];      // low half only
                if (wr_status && bus.wdata[8 + i])      // bit 8+i selects axis
                    enable_q[i] <= bus.wdata[i];
            end
        end
    end

    // ---------------------------------------------------
    // read mux
    // ---------------------------------------------------
    always_comb begin
        rd_next = '0;
        if (rd_main && rd_chan == 4'h0 && rd_off == `QLA_OFF_STATUS)
            rd_next = {board_id, 16'h0, amp_disable, 4'h0, amp_enable};
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            if (rd_main && rd_chan == 4'(i + 1)) begin
                if (rd_off == `QLA_OFF_ADC_DATA)
                    rd_next = {16'h0, fb[i]};
                else if (rd_off == `QLA_OFF_DAC_CTRL)
                    rd_next = {16'h0, dac_cmd[i]};
            end
        end
    end

    always_ff @(posedge clk) rdata <= rd_next;     // one cycle read latency

endmodule

// ==== safety_check.sv ====
/*
 * Per-axis overcurrent check. Trips after QLA_SAFETY_COUNT consecutive bad
 * samples. A sample arriving with clear_disable is ignored.
 */

`include "qla_defines.svh"

module safety_check import qla_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dac_word_t cur_fb,
    input  logic      fb_valid,
    input  dac_word_t cur_cmd,
    input  logic      clear_disable,
    output logic      amp_disable
);

    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);

    dac_word_t        fb_mag;       // |fb - mid|
    dac_word_t        cmd_mag;      // |cmd - mid|
    logic [17:0]      limit;        // 2*cmd + margin, no overflow
    logic             violate;
    logic [CNT_W-1:0] viol_cnt;

    assign fb_mag  = (cur_fb  >= `QLA_DAC_MID) ? cur_fb  - `QLA_DAC_MID : `QLA_DAC_MID - cur_fb;
    assign cmd_mag = (cur_cmd >= `QLA_DAC_MID) ? cur_cmd - `QLA_DAC_MID : `QLA_DAC_MID - cur_cmd;
    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b0, `QLA_SAFETY_MARGIN};
    assign violate = {2'b0, fb_mag} > limit;

    always_ff @(posedge clk) begin
        if (rst) begin
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (fb_valid) begin
            if (!violate) begin
                viol_cnt    <= '0;                  // run broken
            end else if (viol_cnt == CNT_W'(`QLA_SAFETY_COUNT - 1)) begin
                viol_cnt    <= '0;
                amp_disable <= 1'b1;                // latch until cleared
            end else begin
                viol_cnt    <= viol_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== qla_top.sv ====
/*
 * QLA register bus top. Single clock domain; feedback arrives already
 * digitized with a one-cycle fb_valid strobe per sample set.
 */

`include "qla_defines.svh"

module qla_top import qla_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] board_id,
    input  host_req_t  host,
    output logic       ack,
    output reg_data_t  rdata,
    input  rt_wr_t     rt,
    input  dac_word_t  cur_fb [`QLA_NUM_AXES],
    input  logic       fb_valid,
    output dac_word_t  dac_cmd [`QLA_NUM_AXES],
    output axis_mask_t amp_enable
);

    wr_bus_t    host_wr;            // host write, before the mux
    logic       host_wr_pending;
    logic       host_wr_done;
    wr_bus_t    bus;                // muxed write bus
    reg_addr_t  raddr;
    reg_data_t  reg_rdata;
    axis_mask_t amp_disable;        // from safety checks
    axis_mask_t clear_disable;

    // ---------------------------------------------------
    // bus masters
    // ---------------------------------------------------
    host_port host_port_i (
        .clk, .rst, .host, .ack, .rdata,
        .host_wr, .host_wr_pending, .host_wr_done,
        .raddr, .reg_rdata
    );

    rt_block_writer rt_block_writer_i (
        .clk, .rst, .rt, .host_wr, .host_wr_pending, .host_wr_done, .bus
    );

    // ---------------------------------------------------
    // registers and per-axis safety
    // ---------------------------------------------------
    axis_regs axis_regs_i (
        .clk, .rst, .board_id, .bus, .raddr, .rdata(reg_rdata),
        .fb(cur_fb), .amp_disable, .clear_disable, .dac_cmd, .amp_enable
    );

    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_safety
        safety_check safety_check_i (
            .clk, .rst,
            .cur_fb(cur_fb[i]), .fb_valid, .cur_cmd(dac_cmd[i]),
            .clear_disable(clear_disable[i]), .amp_disable(amp_disable[i])
        );
    end

endmodule

// ==== tb_qla_assert.sv ====
/*
 * Handshake and write-bus assertions, bound into qla_top.
 * Sampled on the rising clock, off while rst is high.
 */

module tb_qla_assert import qla_pkg::*; (
    input logic       clk,
    input logic       rst,
    input host_req_t  host,
    input logic       ack,
    input logic       host_wr_done,
    input axis_mask_t amp_enable,
    input axis_mask_t amp_disable
);

    timeunit 1ns;
    timeprecision 1ps;

    // ack only answers a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(host.req))
        else $error("ack rose without req");

    // host may drop req only once ack is up
    req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(host.req) |-> ack)
        else $error("req dropped before ack");

    // a host write takes the bus for one cycle only
    one_writer: assert property (@(posedge clk) disable iff (rst)
        host_wr_done |=> !host_wr_done)
        else $error("host write granted on two cycles in a row");

    // a disable only drops together with the write that enables the axis
    enable_vs_disable: assert property (@(posedge clk) disable iff (rst)
        ($past(amp_disable) & ~amp_disable & ~amp_enable) == '0)
        else $error("disable cleared but axis left off");

endmodule

bind qla_top tb_qla_assert tb_qla_assert_i (
    .clk, .rst, .host, .ack, .host_wr_done, .amp_enable, .amp_disable
);

// ==== tb_qla.sv ====
/*
 * Self-checking testbench for qla_top. Stimulus comes from a 32-bit Galois LFSR
 * and expected values from a register and safety model kept here.
 * Commands are kept small in the safety test so feedback can exceed the limit.
 */

`include "qla_defines.svh"

module tb_qla
    import qla_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAND_WR  = 40;
    localparam int N_SAMPLES  = 24;
    localparam int MAX_WAIT   = 64;         // cycles per handshake phase
    // every op costs well under 20 cycles
    localparam int RUN_CYCLES = (2 * N_RAND_WR + 2 * N_SAMPLES + 60) * 20;
    localparam reg_addr_t STATUS_ADDR = 16'h0000;

    logic       clk;
    logic       rst;
    logic [3:0] board_id;
    host_req_t  host;
    logic       ack;
    reg_data_t  rdata;
    rt_wr_t     rt;
    dac_word_t  cur_fb [`QLA_NUM_AXES];
    logic       fb_valid;
    dac_word_t  dac_cmd [`QLA_NUM_AXES];
    axis_mask_t amp_enable;

    // reference model
    dac_word_t  cmd_m [`QLA_NUM_AXES];
    axis_mask_t en_m;                       // stored enables
    axis_mask_t dis_m;                      // latched safety disables
    int         cnt_m [`QLA_NUM_AXES];      // consecutive bad samples
    reg_data_t  blk_q [$];                  // rt words not yet replayed
    logic [31:0] lfsr_q;

    qla_top qla_top_i (
        .clk, .rst, .board_id, .host, .ack, .rdata, .rt,
        .cur_fb, .fb_valid, .dac_cmd, .amp_enable
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    initial begin
        #(RUN_CYCLES * 4);
        abort_run("watchdog expired before all tests finished");
    end

    // ---------------------------------------------------
    // helpers
    // ---------------------------------------------------
    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic reg_addr_t cmd_addr(input int i);
        return {8'h00, 4'(i + 1), `QLA_OFF_DAC_CTRL};
    endfunction

    function automatic int dist_mid(input dac_word_t v);
        int d;
        d = int'(v) - int'(`QLA_DAC_MID);
        return (d < 0) ? -d : d;
    endfunction

    function automatic reg_data_t exp_status();
        return {board_id, 16'h0, dis_m, 4'h0, en_m & ~dis_m};
    endfunction

    function automatic reg_data_t exp_read(input reg_addr_t addr);
        int ch;
        ch = int'(addr[7:4]);
        if (addr == STATUS_ADDR) return exp_status();
        if (addr[15:8] != 8'h00 || ch < 1 || ch > `QLA_NUM_AXES) return '0;
        if (addr[3:0] == `QLA_OFF_ADC_DATA) return {16'h0, cur_fb[ch - 1]};
        if (addr[3:0] == `QLA_OFF_DAC_CTRL) return {16'h0, cmd_m[ch - 1]};
        return '0;
    endfunction

    function automatic void model_write(input reg_addr_t addr, input reg_data_t data);
        int ch;
        ch = int'(addr[7:4]);
        if (addr == STATUS_ADDR) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (data[8 + i]) begin              // axis select bit
                    en_m[i] = data[i];
                    if (data[i]) begin
                        dis_m[i] = 1'b0;            // enabling clears the trip
                        cnt_m[i] = 0;
                    end
                end
            end
        end else if (addr[15:8] == 8'h00 && addr[3:0] == `QLA_OFF_DAC_CTRL
                     && ch >= 1 && ch <= `QLA_NUM_AXES) begin
            cmd_m[ch - 1] = data[15:0];
        end
    endfunction

    // replay order is axes 1..4, then control word
    function automatic void model_flush();
        reg_data_t w [`QLA_RT_WORDS];
        while (blk_q.size() >= `QLA_RT_WORDS) begin
            for (int k = 0; k < `QLA_RT_WORDS; k++) w[k] = blk_q.pop_front();
            for (int i = 0; i < `QLA_NUM_AXES; i++) model_write(cmd_addr(i), w[i + 1]);
            model_write(STATUS_ADDR, w[0]);
        end
    endfunction

    function automatic void model_sample();
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            if (dist_mid(cur_fb[i]) > 2 * dist_mid(cmd_m[i]) + `QLA_SAFETY_MARGIN) begin
                cnt_m[i]++;
                if (cnt_m[i] == `QLA_SAFETY_COUNT) begin
                    dis_m[i] = 1'b1;
                    en_m[i]  = 1'b0;        // stored enable drops on trip
                    cnt_m[i] = 0;
                end
            end else begin
                cnt_m[i] = 0;
            end
        end
    endfunction

    // ---------------------------------------------------
    // bus drivers
    // ---------------------------------------------------
    task automatic host_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                               output reg_data_t data, output int cycles);
        int k;
        @(posedge clk);
        #1;
        host = '{req: 1'b1, write: wr, addr: addr, wdata: wdata};
        cycles = 0;
        while (!ack && cycles < MAX_WAIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ack) abort_run("host access got no ack");
        data = rdata;                       // valid while ack high
        host.req = 1'b0;
        k = 0;
        while (ack && k < MAX_WAIT) begin
            @(posedge clk);
            #1;
            k++;
        end
        if (ack) abort_run("ack stayed high after req dropped");
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        reg_data_t unused;
        int cycles;
        host_access(1'b1, addr, data, unused, cycles);
        model_flush();                      // pending replays land first
        model_write(addr, data);
    endtask

    task automatic read_check(input reg_addr_t addr);
        reg_data_t data;
        int cycles;
        host_access(1'b0, addr, '0, data, cycles);
        check("read ack latency", cycles, 3);
        check($sformatf("rdata[%h]", addr), data, exp_read(addr));
    endtask

    // disable bits as the status register reports them
    task automatic check_disables(input string name, input axis_mask_t exp);
        reg_data_t data;
        int cycles;
        host_access(1'b0, STATUS_ADDR, '0, data, cycles);
        check(name, 32'(data[11:8]), 32'(exp));
    endtask

    task automatic send_rt_block();
        reg_data_t w;
        for (int k = 0; k < `QLA_RT_WORDS; k++) begin
            w = rand_bits(32);
            @(posedge clk);
            #1;
            rt = '{wen: 1'b1, waddr: rt_addr_t'(k), wdata: w};
            blk_q.push_back(w);
        end
        @(posedge clk);
        #1;
        rt.wen = 1'b0;
    endtask

    // one feedback set, bad axes pushed past their limit
    task automatic fb_sample(input axis_mask_t bad);
        dac_word_t mag;
        int lim;
        @(posedge clk);
        #1;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            lim = 2 * dist_mid(cmd_m[i]) + `QLA_SAFETY_MARGIN;
            if (bad[i])
                mag = dac_word_t'(lim + 1 + int'(rand_bits(8)));
            else
                mag = dac_word_t'(int'(rand_bits(11)) % (lim + 1));
            cur_fb[i] = rand_bits(1) ? `QLA_DAC_MID + mag : `QLA_DAC_MID - mag;
        end
        fb_valid = 1'b1;
        @(posedge clk);
        #1;
        fb_valid = 1'b0;
        model_sample();
        check("amp_enable", 32'(amp_enable), 32'(en_m & ~dis_m));
    endtask

    task automatic check_outputs();
        for (int i = 0; i < `QLA_NUM_AXES; i++)
            check($sformatf("dac_cmd[%0d]", i), 32'(dac_cmd[i]), 32'(cmd_m[i]));
        check("amp_enable", 32'(amp_enable), 32'(en_m & ~dis_m));
    endtask

    task automatic read_all();
        read_check(STATUS_ADDR);
        for (int i = 0; i < `QLA_NUM_AXES; i++) read_check(cmd_addr(i));
    endtask

    // ---------------------------------------------------
    // test sequence
    // ---------------------------------------------------
    initial begin
        reg_addr_t  addr;
        axis_mask_t run_bad;
        axis_mask_t trip;
        int         run_len [`QLA_NUM_AXES];
        int         sel;
        lfsr_q   = 32'd96409;
        rst      = 1'b1;
        board_id = 4'(rand_bits(4));
        host     = '0;
        rt       = '0;
        fb_valid = 1'b0;
        en_m     = '0;
        dis_m    = '0;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            cur_fb[i] = `QLA_DAC_MID;
            cmd_m[i]  = `QLA_DAC_MID;
            cnt_m[i]  = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values
        check("ack", 32'(ack), 32'h0);
        check_outputs();
        read_all();

        // random host writes, read back each one
        for (int n = 0; n < N_RAND_WR; n++) begin
            sel  = int'(rand_bits(3)) % 5;
            addr = (sel == 0) ? STATUS_ADDR : cmd_addr(sel - 1);
            host_write(addr, rand_bits(32));
            read_check(addr);
        end
        read_check(16'h1000);               // other space
        read_check(16'h0051);               // no such channel
        check_outputs();

        // rt block alone, gap longer than a replay
        send_rt_block();
        repeat (2 * `QLA_RT_WORDS) @(posedge clk);
        #1;
        model_flush();
        check_outputs();
        read_all();

        // host write lands while the replay runs
        for (int r = 0; r < 3; r++) begin
            fork
                send_rt_block();
                begin
                    repeat (5) @(posedge clk);
                    host_write(cmd_addr(int'(rand_bits(2))), rand_bits(32));
                end
            join
            check_outputs();
            read_all();
        end

        // small commands, all axes on
        for (int i = 0; i < `QLA_NUM_AXES; i++)
            host_write(cmd_addr(i), rand_bits(1) ? {16'h0, `QLA_DAC_MID + 16'(rand_bits(10))}
                                                 : {16'h0, `QLA_DAC_MID - 16'(rand_bits(10))});
        host_write(STATUS_ADDR, 32'h0000_0F0F);

        // violation runs shorter than the trip count
        for (int i = 0; i < `QLA_NUM_AXES; i++) run_len[i] = 0;
        for (int n = 0; n < N_SAMPLES; n++) begin
            run_bad = '0;
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (rand_bits(1) != 0 && run_len[i] < `QLA_SAFETY_COUNT - 1) begin
                    run_bad[i] = 1'b1;
                    run_len[i]++;
                end else begin
                    run_len[i] = 0;
                end
            end
            fb_sample(run_bad);
        end
        check_disables("status disables after short runs", '0);
        read_check(STATUS_ADDR);

        // full run on a random set of axes
        trip = axis_mask_t'(rand_bits(4)) | axis_mask_t'(1);
        fb_sample('0);                      // break any partial run
        repeat (`QLA_SAFETY_COUNT) fb_sample(trip);
        check_disables("status disables after trip", trip);
        read_check(STATUS_ADDR);
        read_check({8'h00, 4'h1, `QLA_OFF_ADC_DATA});
        check_outputs();

        // re-enable clears the trip
        host_write(STATUS_ADDR, {20'h0, trip, 4'h0, trip});
        check_disables("status disables after re-enable", '0);
        read_check(STATUS_ADDR);
        check_outputs();

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
qla_pkg.sv
host_port.sv
rt_block_writer.sv
axis_regs.sv
safety_check.sv
qla_top.sv
tb_qla_assert.sv
tb_qla.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_qla
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) qla_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
